// File: include/conv_config.svh
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

////////////////////
// Layer geometry
////////////////////

// Output channels computed side by side
`define CONV_LANES 4
// Kernel side and input channels
`define CONV_KDIM 3
`define CONV_CHIN 2
// One window is every kernel position of every input channel
`define CONV_TAPS (`CONV_KDIM * `CONV_KDIM * `CONV_CHIN)
// Output map is CONV_WOUT by CONV_WOUT pixels
`define CONV_WOUT 4
// Output buffer entries, also the starting credit count
`define CONV_FIFO_DEPTH 4

`endif

// File: design/conv_data_pkg.sv
`include "conv_config.svh"

package conv_data_pkg;

	// Input pixel and kernel weight
	typedef logic signed [15:0] pixel_t;
	// Accumulator, products and bias
	typedef logic signed [31:0] acc_t;
	// Requantized output word
	typedef logic [15:0] ofm_t;

	// Lane 0 sits in the low bits of both vectors
	typedef logic [`CONV_LANES*16-1:0] ofm_vec_t;
	typedef logic [`CONV_LANES*16-1:0] weight_vec_t;

endpackage

// File: design/conv_ctrl_pkg.sv
`include "conv_config.svh"

package conv_ctrl_pkg;

	// Counters
	typedef logic [$clog2(`CONV_TAPS)-1:0] tap_t;
	// Must reach the full pixel count, not just the last index
	typedef logic [$clog2(`CONV_WOUT*`CONV_WOUT+1)-1:0] pix_t;
	typedef logic [$clog2(`CONV_FIFO_DEPTH+1)-1:0] credit_t;
	typedef logic [7:0] ofm_addr_t;

	// State machines
	typedef enum logic [2:0] {
		core_idle, core_wait_credit, core_accumulate, core_finish, core_done
	} core_state_t;

	typedef enum logic [1:0] {writer_idle, writer_write, writer_done} writer_state_t;

endpackage

// File: design/kernel_rom.sv
`include "conv_config.svh"

module kernel_rom
	import conv_data_pkg::*;
	import conv_ctrl_pkg::*;
(
	input  logic        clk,
	input  tap_t        rom_tap,
	output weight_vec_t rom_weights,
	output acc_t        bias [`CONV_LANES]
);

	// One packed row of lane weights per tap
	weight_vec_t weight_mem [`CONV_TAPS];
	// One bias per lane
	acc_t bias_mem [`CONV_LANES];

	////////////////////
	// Image load
	////////////////////

	initial begin
		$readmemh("weights.hex", weight_mem);
		$readmemh("bias.hex", bias_mem);
	end

	////////////////////
	// Read ports
	////////////////////

	// Registered read, lines up with the core's pixel register
	always_ff @(posedge clk) begin
		rom_weights <= weight_mem[rom_tap];
	end

	// Bias table never changes during a layer
	always_comb begin
		for (int l = 0; l < `CONV_LANES; l++) begin
			bias[l] = bias_mem[l];
		end
	end

endmodule

// File: design/conv_core.sv
`include "conv_config.svh"

module conv_core
	import conv_data_pkg::*;
	import conv_ctrl_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        start,
	input  pixel_t      ifm_pixel,
	input  logic        ifm_valid,
	output logic        ifm_ready,
	output tap_t        rom_tap,
	input  weight_vec_t rom_weights,
	input  acc_t        bias [`CONV_LANES],
	output logic        push,
	output ofm_vec_t    push_data,
	input  logic        credit_return
);

	localparam int WINDOWS = `CONV_WOUT * `CONV_WOUT;
	localparam int OFM_W = $bits(ofm_t);

	core_state_t state;
	// Tap position inside the current window
	tap_t clr_counter;
	credit_t credits;
	pix_t win_started;
	pix_t win_pushed;
	logic accept;
	logic spend;

	// Pipeline stages
	pixel_t pix_reg;
	logic mac_en;
	logic mac_clear;
	logic temp_clr_pulse;
	logic clr_pulse;
	pixel_t lane_weight [`CONV_LANES];
	acc_t acc [`CONV_LANES];
	acc_t biased [`CONV_LANES];

	////////////////////
	// Input handshake
	////////////////////

	// Mid-window the credit is already spent
	always_comb begin
		case (state)
			core_wait_credit: ifm_ready = (credits != '0);
			core_accumulate:  ifm_ready = 1'b1;
			default:          ifm_ready = 1'b0;
		endcase
	end

	assign accept = ifm_valid && ifm_ready;
	// First tap of a window takes a credit
	assign spend = accept && (state == core_wait_credit);
	assign rom_tap = clr_counter;

	////////////////////
	// Window sequencing
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= core_idle;
			clr_counter <= '0;
			win_started <= '0;
		end else begin
			case (state)
				core_idle, core_done: begin
					if (start) begin
						state <= core_wait_credit;
						clr_counter <= '0;
						win_started <= '0;
					end
				end
				core_wait_credit, core_accumulate: begin
					if (accept) begin
						if (clr_counter == tap_t'(`CONV_TAPS - 1)) begin
							clr_counter <= '0;
							win_started <= win_started + 1'b1;
							// Last window taken, only the drain is left
							if (win_started == pix_t'(WINDOWS - 1))
								state <= core_finish;
							else
								state <= core_wait_credit;
						end else begin
							clr_counter <= clr_counter + 1'b1;
							state <= core_accumulate;
						end
					end
				end
				core_finish: begin
					if (win_pushed == pix_t'(WINDOWS))
						state <= core_done;
				end
				default: state <= core_idle;
			endcase
		end
	end

	// Layer end detection, counts vectors handed to the buffer
	always_ff @(posedge clk) begin
		if (reset)
			win_pushed <= '0;
		else if (start && (state == core_idle || state == core_done))
			win_pushed <= '0;
		else if (push)
			win_pushed <= win_pushed + 1'b1;
	end

	// Spend and return may land on the same edge
	always_ff @(posedge clk) begin
		if (reset)
			credits <= credit_t'(`CONV_FIFO_DEPTH);
		else
			credits <= credits - credit_t'(spend) + credit_t'(credit_return);
	end

	////////////////////
	// Clear and capture pulses
	////////////////////

	// Accept, then MAC, then bias and quantize, then push
	always_ff @(posedge clk) begin
		if (reset) begin
			mac_en <= 1'b0;
			mac_clear <= 1'b0;
			temp_clr_pulse <= 1'b0;
			clr_pulse <= 1'b0;
			push <= 1'b0;
		end else begin
			mac_en <= accept;
			mac_clear <= accept && (clr_counter == '0);
			temp_clr_pulse <= accept && (clr_counter == tap_t'(`CONV_TAPS - 1));
			clr_pulse <= temp_clr_pulse;
			push <= clr_pulse;
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			pix_reg <= ifm_pixel;
	end

	////////////////////
	// Lane MAC array
	////////////////////

	always_comb begin
		for (int l = 0; l < `CONV_LANES; l++) begin
			lane_weight[l] = pixel_t'(rom_weights[l*16 +: 16]);
			biased[l] = acc[l] + bias[l];
		end
	end

	// First tap loads the product instead of adding
	always_ff @(posedge clk) begin
		for (int l = 0; l < `CONV_LANES; l++) begin
			if (mac_en) begin
				if (mac_clear)
					acc[l] <= acc_t'(pix_reg) * acc_t'(lane_weight[l]);
				else
					acc[l] <= acc[l] + acc_t'(pix_reg) * acc_t'(lane_weight[l]);
			end
		end
	end

	// ReLU then plain slice of bits 28..14
	always_ff @(posedge clk) begin
		if (clr_pulse) begin
			for (int l = 0; l < `CONV_LANES; l++) begin
				if (biased[l][31])
					push_data[l*OFM_W +: OFM_W] <= '0;
				else
					push_data[l*OFM_W +: OFM_W] <= {1'b0, biased[l][28:14]};
			end
		end
	end

	////////////////////
	// Checks
	////////////////////

	a_credit_max: assert property (@(posedge clk) disable iff (reset)
		credits <= credit_t'(`CONV_FIFO_DEPTH))
		else $error("credit count above buffer depth");

	// Pushed window still holds its credit
	a_push_credit: assert property (@(posedge clk) disable iff (reset)
		push |-> credits < credit_t'(`CONV_FIFO_DEPTH))
		else $error("push without a spent credit");

endmodule

// File: design/ofm_fifo.sv
`include "conv_config.svh"

module ofm_fifo
	import conv_data_pkg::*;
	import conv_ctrl_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     push,
	input  ofm_vec_t push_data,
	output logic     head_valid,
	output ofm_vec_t head_data,
	input  logic     pop,
	output logic     credit_return
);

	localparam int DEPTH = `CONV_FIFO_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	ofm_vec_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	// Fill level
	credit_t count;
	logic do_pop;

	// Wrap also for depths that are not a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	////////////////////
	// Head and credits
	////////////////////

	assign head_valid = (count != '0);
	assign head_data = mem[rd_ptr];
	assign do_pop = pop && head_valid;
	// Freed entry goes straight back to the core
	assign credit_return = do_pop;

	////////////////////
	// Storage
	////////////////////

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			count <= count + credit_t'(push) - credit_t'(do_pop);
		end
	end

	// Credits should make overflow impossible
	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		push |-> count < credit_t'(DEPTH))
		else $error("push into full buffer");

	a_no_underflow: assert property (@(posedge clk) disable iff (reset)
		pop |-> count != '0)
		else $error("pop from empty buffer");

endmodule

// File: design/ofm_writer.sv
`include "conv_config.svh"

module ofm_writer
	import conv_data_pkg::*;
	import conv_ctrl_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      start,
	input  logic      head_valid,
	input  ofm_vec_t  head_data,
	output logic      pop,
	output logic      ofm_we,
	output ofm_addr_t ofm_addr,
	output ofm_t      ofm_data,
	input  logic      ofm_ready,
	output logic      layer_done
);

	localparam int WINDOWS = `CONV_WOUT * `CONV_WOUT;
	localparam int OFM_W = $bits(ofm_t);
	localparam int LANE_W = (`CONV_LANES > 1) ? $clog2(`CONV_LANES) : 1;

	writer_state_t state;
	// Local copy of the head vector
	ofm_vec_t word_vec;
	logic [LANE_W-1:0] lane_idx;
	pix_t pix_idx;
	logic word_taken;
	logic last_word;
	logic load;

	assign word_taken = ofm_we && ofm_ready;
	assign last_word = word_taken && (lane_idx == LANE_W'(`CONV_LANES - 1));
	// Wait out the pop cycle, the head is still the old vector then
	assign load = (state == writer_write) && !ofm_we && !pop && head_valid;

	////////////////////
	// Word sequencing
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= writer_idle;
			ofm_we <= 1'b0;
			pop <= 1'b0;
			lane_idx <= '0;
			pix_idx <= '0;
		end else begin
			pop <= 1'b0;
			case (state)
				writer_idle, writer_done: begin
					// Restart goes straight to writing
					if (start) begin
						state <= writer_write;
						lane_idx <= '0;
						pix_idx <= '0;
					end
				end
				writer_write: begin
					if (last_word) begin
						ofm_we <= 1'b0;
						pop <= 1'b1;
						lane_idx <= '0;
						pix_idx <= pix_idx + 1'b1;
						if (pix_idx == pix_t'(WINDOWS - 1))
							state <= writer_done;
					end else if (word_taken) begin
						lane_idx <= lane_idx + 1'b1;
					end else if (load) begin
						ofm_we <= 1'b1;
					end
				end
				default: state <= writer_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (load)
			word_vec <= head_data;
	end

	////////////////////
	// Write port
	////////////////////

	// Address is pixel times lanes plus lane
	assign ofm_addr = ofm_addr_t'(pix_idx * `CONV_LANES + lane_idx);
	assign ofm_data = word_vec[lane_idx*OFM_W +: OFM_W];
	assign layer_done = (state == writer_done);

	// Stalled word must not move
	a_addr_hold: assert property (@(posedge clk) disable iff (reset)
		ofm_we && !ofm_ready |=> ofm_we && $stable(ofm_addr))
		else $error("output word changed under back-pressure");

endmodule

// File: design/conv_layer.sv
`include "conv_config.svh"

module conv_layer
	import conv_data_pkg::*;
	import conv_ctrl_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      start,
	input  pixel_t    ifm_pixel,
	input  logic      ifm_valid,
	output logic      ifm_ready,
	output logic      ofm_we,
	output ofm_addr_t ofm_addr,
	output ofm_t      ofm_data,
	input  logic      ofm_ready,
	output logic      layer_done
);

	// ROM side
	tap_t rom_tap;
	weight_vec_t rom_weights;
	acc_t bias [`CONV_LANES];

	// Core to buffer
	logic push;
	ofm_vec_t push_data;
	logic credit_return;

	// Buffer to writer
	logic head_valid;
	ofm_vec_t head_data;
	logic pop;

	kernel_rom u_rom (
		.clk         (clk),
		.rom_tap     (rom_tap),
		.rom_weights (rom_weights),
		.bias        (bias)
	);

	conv_core u_core (
		.clk           (clk),
		.reset         (reset),
		.start         (start),
		.ifm_pixel     (ifm_pixel),
		.ifm_valid     (ifm_valid),
		.ifm_ready     (ifm_ready),
		.rom_tap       (rom_tap),
		.rom_weights   (rom_weights),
		.bias          (bias),
		.push          (push),
		.push_data     (push_data),
		.credit_return (credit_return)
	);

	ofm_fifo u_fifo (
		.clk           (clk),
		.reset         (reset),
		.push          (push),
		.push_data     (push_data),
		.head_valid    (head_valid),
		.head_data     (head_data),
		.pop           (pop),
		.credit_return (credit_return)
	);

	ofm_writer u_writer (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.head_valid (head_valid),
		.head_data  (head_data),
		.pop        (pop),
		.ofm_we     (ofm_we),
		.ofm_addr   (ofm_addr),
		.ofm_data   (ofm_data),
		.ofm_ready  (ofm_ready),
		.layer_done (layer_done)
	);

endmodule

// File: bench/conv_layer_tb.sv
`include "conv_config.svh"

module conv_layer_tb
	import conv_data_pkg::*;
	import conv_ctrl_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int WINDOWS = `CONV_WOUT * `CONV_WOUT;
	localparam int WORDS = WINDOWS * `CONV_LANES;
	localparam int PIXELS = WINDOWS * `CONV_TAPS;
	// Five layers of pixels and words with 4x stall headroom plus margin
	localparam int TIMEOUT_CYCLES = 5 * (PIXELS + WORDS) * 4 + 500;
	localparam logic [31:0] SEED = 32'h4c702d82;

	logic clk;
	logic reset;
	logic start;
	pixel_t ifm_pixel;
	logic ifm_valid;
	logic ifm_ready;
	logic ofm_we;
	ofm_addr_t ofm_addr;
	ofm_t ofm_data;
	logic ofm_ready;
	logic layer_done;

	// Reference images and model results
	weight_vec_t weight_ref [`CONV_TAPS];
	acc_t bias_ref [`CONV_LANES];
	pixel_t pixels [PIXELS];
	ofm_t expected [WORDS];
	logic negative [WORDS];

	// Output memory model
	ofm_t mem_data [WORDS];
	int write_count [WORDS];
	int writes_total;

	// Separate streams for stimulus and output stalls
	logic [31:0] stim_state;
	logic [31:0] ready_state;
	logic stall_output;
	logic input_gaps;
	logic saw_input_stall;
	int cycle_count;

	conv_layer dut (
		.clk        (clk),
		.reset      (reset),
		.start      (start),
		.ifm_pixel  (ifm_pixel),
		.ifm_valid  (ifm_valid),
		.ifm_ready  (ifm_ready),
		.ofm_we     (ofm_we),
		.ofm_addr   (ofm_addr),
		.ofm_data   (ofm_data),
		.ofm_ready  (ofm_ready),
		.layer_done (layer_done)
	);

	task automatic fail_now(input string what);
		$display("%s", what);
		$display("*** TEST FAILED ***");
		$fatal(1, "stopping at first failure");
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	////////////////////
	// Clock, timeout, output side
	////////////////////

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
			fail_now("Timeout, the layer never finished");
	end

	// Roughly one ready cycle in eight when stalling
	always @(negedge clk) begin
		if (stall_output) begin
			ready_state = xorshift(ready_state);
			ofm_ready = (ready_state[2:0] == 3'd0);
		end else begin
			ofm_ready = 1'b1;
		end
	end

	// Samples the word the bus held before the edge
	always @(posedge clk) begin
		if (!reset && ofm_we && ofm_ready) begin
			assert (ofm_addr < ofm_addr_t'(WORDS))
				else fail_now($sformatf("Error: ofm_addr 0x%02h beyond last word 0x%02h",
					ofm_addr, WORDS - 1));
			// Words arrive lane by lane and pixel by pixel
			assert (ofm_addr == ofm_addr_t'(writes_total))
				else fail_now($sformatf("Error: ofm_addr 0x%02h, expected 0x%02h",
					ofm_addr, writes_total));
			mem_data[ofm_addr] = ofm_data;
			write_count[ofm_addr]++;
			writes_total++;
		end
	end

	////////////////////
	// Reference model
	////////////////////

	// Sum of products plus bias through ReLU and bits 28..14
	task automatic build_expected();
		acc_t sum;
		pixel_t w;
		for (int p = 0; p < WINDOWS; p++) begin
			for (int l = 0; l < `CONV_LANES; l++) begin
				sum = '0;
				for (int t = 0; t < `CONV_TAPS; t++) begin
					w = weight_ref[t][l*16 +: 16];
					sum = sum + acc_t'(pixels[p*`CONV_TAPS + t]) * acc_t'(w);
				end
				sum = sum + bias_ref[l];
				negative[p*`CONV_LANES + l] = sum[31];
				expected[p*`CONV_LANES + l] = sum[31] ? ofm_t'(0) : {1'b0, sum[28:14]};
			end
		end
	endtask

	// Signed pixels within 13 bits keep the sums clear of wrap
	task automatic gen_pixels(input bit positive_only);
		for (int i = 0; i < PIXELS; i++) begin
			stim_state = xorshift(stim_state);
			if (positive_only)
				pixels[i] = {4'h0, stim_state[11:0]};
			else
				pixels[i] = {{3{stim_state[12]}}, stim_state[12:0]};
		end
		build_expected();
	endtask

	////////////////////
	// Drivers
	////////////////////

	task automatic pulse_start();
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic feed_pixels();
		int i;
		i = 0;
		while (i < PIXELS) begin
			@(negedge clk);
			stim_state = xorshift(stim_state);
			ifm_valid = input_gaps ? stim_state[0] : 1'b1;
			ifm_pixel = pixels[i];
			// ifm_ready only moves on the rising edge
			if (ifm_valid && ifm_ready)
				i++;
			else if (ifm_valid)
				saw_input_stall = 1'b1;
		end
		@(negedge clk);
		ifm_valid = 1'b0;
	endtask

	task automatic wait_layer_done();
		while (!layer_done)
			@(negedge clk);
		assert (writes_total == WORDS)
			else fail_now($sformatf("Error: writes_total 0x%0h at layer_done, expected 0x%0h",
				writes_total, WORDS));
	endtask

	task automatic check_memory();
		for (int a = 0; a < WORDS; a++) begin
			assert (write_count[a] == 1)
				else fail_now($sformatf("Address 0x%02h was never written", a));
			assert (mem_data[a] == expected[a])
				else fail_now($sformatf(
					"Error: ofm_data at ofm_addr 0x%02h is 0x%04h, expected 0x%04h",
					a, mem_data[a], expected[a]));
		end
	endtask

	// One full layer with the chosen input and output behavior
	task automatic run_layer(input bit gaps, input bit stall);
		@(posedge clk);
		input_gaps = gaps;
		stall_output = stall;
		saw_input_stall = 1'b0;
		writes_total = 0;
		for (int a = 0; a < WORDS; a++) begin
			write_count[a] = 0;
			mem_data[a] = '0;
		end
		pulse_start();
		assert (!layer_done)
			else fail_now($sformatf("Error: layer_done 0x%0h after start, expected 0x0",
				layer_done));
		fork
			feed_pixels();
			wait_layer_done();
		join
		assert (!ifm_ready)
			else fail_now("ifm_ready stayed high after the layer ended");
		check_memory();
	endtask

	////////////////////
	// Tests
	////////////////////

	task automatic streaming_run();
		gen_pixels(1'b0);
		run_layer(1'b0, 1'b0);
	endtask

	task automatic backpressure_run();
		gen_pixels(1'b0);
		run_layer(1'b0, 1'b1);
		assert (saw_input_stall)
			else fail_now("ifm_ready never dropped while the output was stalled");
	endtask

	task automatic input_gap_run();
		gen_pixels(1'b0);
		run_layer(1'b1, 1'b0);
	endtask

	// Lane 3 has only negative weights
	task automatic relu_clamp_run();
		int negatives;
		gen_pixels(1'b1);
		negatives = 0;
		for (int a = 0; a < WORDS; a++)
			negatives += negative[a];
		assert (negatives > 0 && negatives < WORDS)
			else fail_now("ReLU stimulus gave no mix of negative and positive sums");
		run_layer(1'b0, 1'b0);
	endtask

	task automatic restart_run();
		assert (layer_done)
			else fail_now("layer_done was low before the restart");
		gen_pixels(1'b0);
		run_layer(1'b1, 1'b1);
	endtask

	initial begin
		reset = 1'b1;
		start = 1'b0;
		ifm_pixel = '0;
		ifm_valid = 1'b0;
		ofm_ready = 1'b1;
		stall_output = 1'b0;
		input_gaps = 1'b0;
		saw_input_stall = 1'b0;
		stim_state = SEED;
		ready_state = SEED ^ 32'h9e3779b9;
		cycle_count = 0;
		writes_total = 0;
		$readmemh("weights.hex", weight_ref);
		$readmemh("bias.hex", bias_ref);
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		// Quiet outputs before any start
		assert (!ifm_ready)
			else fail_now($sformatf("Error: ifm_ready 0x%0h after reset, expected 0x0", ifm_ready));
		assert (!ofm_we)
			else fail_now($sformatf("Error: ofm_we 0x%0h after reset, expected 0x0", ofm_we));
		assert (!layer_done)
			else fail_now($sformatf("Error: layer_done 0x%0h after reset, expected 0x0",
				layer_done));
		streaming_run();
		backpressure_run();
		input_gap_run();
		relu_clamp_run();
		restart_run();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+include
design/conv_data_pkg.sv
design/conv_ctrl_pkg.sv
design/kernel_rom.sv
design/conv_core.sv
design/ofm_fifo.sv
design/ofm_writer.sv
design/conv_layer.sv
bench/conv_layer_tb.sv

// File: weights.hex
// One row per tap 0 to 17
// Digits hold lane 3 down to lane 0 as 16-bit signed weights
F900034001200210
FA80FD10020001F0
FC40048000880300
F810FB6001500122
FE200250FF900404
F9C0061002300098
FB00FCE003100276
FD80012000440188
F880F9A0027003A0
FC10053001C00066
FA20FE40FFC002E4
FF00039003300150
F940FC8000980410
FB700410026001B2
FD30FD9001800320
F8C00280FF2000F0
FC90FEE002900244
FA500570011003C8

// File: bias.hex
// Bias of lane 0 to lane 3 as 32-bit signed values
00001000
FFFF0000
00020000
00004000
